// ==== sim.f ====
+incdir+.
uart_pkg.sv
uart_cmd_tx.sv
uart_frame_rx.sv
uart_top.sv
tb_uart_top.sv

// ==== uart_cases.txt ====
# name kind fields, all fields hex. C cmd | D cmd second_cmd | G low_clocks
# R data bad_parity bad_stop expected_parity_err expected_frame_err
cmd_zero        C 0000
cmd_ones        C ffff
cmd_seq         C 1234
cmd_alt         C a55a
cmd_walk_ends   C 8001
cmd_mix         C 3c96
cmd_odd_ones    C 0701
rx_plain_00     R 00 0 0 0 0
rx_plain_ff     R ff 0 0 0 0
rx_plain_5a     R 5a 0 0 0 0
rx_bad_par_a5   R a5 1 0 1 0
rx_bad_par_01   R 01 1 0 1 0
rx_bad_stop_3c  R 3c 0 1 0 1
rx_bad_stop_80  R 80 0 1 0 1
rx_bad_both_7e  R 7e 1 1 1 1
cmd_second_a    D beef 0f0f
cmd_second_b    D 0102 ffff
glitch_1        G 1
glitch_2        G 2
glitch_3        G 3
cmd_after_glt   C c001
rx_after_glt    R 96 0 0 0 0

// ==== tb_uart_top.sv ====
`timescale 1ns/1ps
`include "uart_defs.svh"

module tb_uart_top;

   localparam int CPB         = `CLKS_PER_BIT;
   localparam int CMD_BITS    = 2 * `FRAME_BITS;
   localparam int WAIT_LIMIT  = 4 * `FRAME_BITS * `CLKS_PER_BIT;
   localparam int RANDOM_CMDS = 6;

   logic            clk;
   logic            rst_n;
   uart_pkg::cmd_t  cmd_in;
   logic            cmd_vld;
   logic            cmd_rdy;
   logic            tx;
   logic            rx;
   logic            rx_drv;
   logic            loopback;
   logic            read_rdy;
   uart_pkg::byte_t read_data;
   logic            parity_err;
   logic            frame_err;

   integer seed;

   // In loopback the receiver listens to the transmitter.
   assign rx = loopback ? tx : rx_drv;

   uart_top i_uart_top (
      .clk        (clk),
      .rst_n      (rst_n),
      .cmd_in     (cmd_in),
      .cmd_vld    (cmd_vld),
      .cmd_rdy    (cmd_rdy),
      .tx         (tx),
      .rx         (rx),
      .read_rdy   (read_rdy),
      .read_data  (read_data),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #2 clk = ~clk;
      end
   end

   // **************************************************
   // Reporting and compare tasks
   // **************************************************

   task automatic stop_run();
      $display("Result: FAILED");
      $fatal(1);
   endtask

   task automatic report_timeout(input string name, input string what);
      $display("Timeout in test %s while waiting for %s.", name, what);
      stop_run();
   endtask

   task automatic check_byte(input string name, input string what,
                             input uart_pkg::byte_t expected, input uart_pkg::byte_t actual);
      if (actual !== expected) begin
         $display("Error: %s %s expected %h actual %h", name, what, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_frame(input string name, input string what,
                              input uart_pkg::frame_t expected, input uart_pkg::frame_t actual);
      if (actual !== expected) begin
         $display("Error: %s %s expected %b actual %b", name, what, expected, actual);
         stop_run();
      end
   endtask

   task automatic check_flag(input string name, input string what,
                             input logic expected, input logic actual);
      if (actual !== expected) begin
         $display("Error: %s %s expected %b actual %b", name, what, expected, actual);
         stop_run();
      end
   endtask

   // Line image of one frame, bit 0 first on the wire.
   function automatic uart_pkg::frame_t make_frame(input uart_pkg::byte_t data,
                                                   input logic bad_par, input logic bad_stop);
      uart_pkg::frame_t frame;
      int ones;
      ones  = 0;
      frame = '0;
      for (int i = 0; i < 8; i++) begin
         frame[i + 1] = data[i];
         if (data[i]) begin
            ones++;
         end
      end
      frame[9]  = (ones % 2 == 0) ? 1'b1 : 1'b0;
      frame[10] = 1'b1;
      if (bad_par) begin
         frame[9] = ~frame[9];
      end
      if (bad_stop) begin
         frame[10] = 1'b0;
      end
      return frame;
   endfunction

   task automatic wait_cmd_rdy(input string name);
      int waited;
      waited = 0;
      while (!cmd_rdy) begin
         if (waited >= WAIT_LIMIT) begin
            report_timeout(name, "cmd_rdy");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   // Always moves at least one clock, so a pulse is never counted twice.
   task automatic wait_read_rdy(input string name);
      int waited;
      waited = 0;
      @(negedge clk);
      while (!read_rdy) begin
         if (waited >= WAIT_LIMIT) begin
            report_timeout(name, "read_rdy");
         end
         waited++;
         @(negedge clk);
      end
   endtask

   // **************************************************
   // Test kinds
   // **************************************************

   task automatic run_command(input string name, input uart_pkg::cmd_t cmd,
                              input logic second, input uart_pkg::cmd_t other);
      uart_pkg::frame_t    exp_hi;
      uart_pkg::frame_t    exp_lo;
      logic [CMD_BITS-1:0] seen;
      exp_hi = make_frame(cmd[15:8], 1'b0, 1'b0);
      exp_lo = make_frame(cmd[7:0], 1'b0, 1'b0);
      wait_cmd_rdy(name);
      loopback = 1'b1;
      cmd_in   = cmd;
      cmd_vld  = 1'b1;
      @(negedge clk);
      cmd_vld = 1'b0;
      fork
         begin
            // Half a clock into the start bit now, so step to the bit middles.
            repeat (CPB / 2) @(negedge clk);
            for (int i = 0; i < CMD_BITS; i++) begin
               seen[i] = tx;
               if (i < CMD_BITS - 1) begin
                  repeat (CPB) @(negedge clk);
               end
            end
            check_frame(name, "high frame", exp_hi, seen[`FRAME_BITS-1:0]);
            check_frame(name, "low frame", exp_lo, seen[CMD_BITS-1:`FRAME_BITS]);
         end
         begin
            repeat (CMD_BITS * CPB) begin
               check_flag(name, "cmd_rdy busy", 1'b0, cmd_rdy);
               @(negedge clk);
            end
            check_flag(name, "cmd_rdy done", 1'b1, cmd_rdy);
         end
         begin
            wait_read_rdy(name);
            check_byte(name, "high byte", cmd[15:8], read_data);
            check_flag(name, "high parity_err", 1'b0, parity_err);
            check_flag(name, "high frame_err", 1'b0, frame_err);
            wait_read_rdy(name);
            check_byte(name, "low byte", cmd[7:0], read_data);
            check_flag(name, "low parity_err", 1'b0, parity_err);
            check_flag(name, "low frame_err", 1'b0, frame_err);
         end
         begin
            if (second) begin
               repeat (5 * CPB) @(negedge clk);
               cmd_in  = other;
               cmd_vld = 1'b1;
               @(negedge clk);
               cmd_vld = 1'b0;
            end
         end
      join
      check_flag(name, "tx idle", 1'b1, tx);
   endtask

   task automatic run_frame(input string name, input uart_pkg::byte_t data,
                            input logic bad_par, input logic bad_stop,
                            input logic exp_perr, input logic exp_ferr);
      uart_pkg::frame_t frame;
      frame    = make_frame(data, bad_par, bad_stop);
      loopback = 1'b0;
      fork
         begin
            for (int i = 0; i < `FRAME_BITS; i++) begin
               rx_drv = frame[i];
               repeat (CPB) @(negedge clk);
            end
            rx_drv = 1'b1;
         end
         begin
            wait_read_rdy(name);
            check_byte(name, "read_data", data, read_data);
            check_flag(name, "parity_err", exp_perr, parity_err);
            check_flag(name, "frame_err", exp_ferr, frame_err);
         end
      join
      // One idle bit so the next start edge is clean.
      repeat (CPB) @(negedge clk);
   endtask

   task automatic run_glitch(input string name, input int width);
      loopback = 1'b0;
      rx_drv   = 1'b0;
      repeat (width) @(negedge clk);
      rx_drv = 1'b1;
      repeat (`FRAME_BITS * CPB) begin
         check_flag(name, "read_rdy", 1'b0, read_rdy);
         @(negedge clk);
      end
   endtask

   task automatic check_fields(input string name, input int got, input int want);
      if (got != want) begin
         $display("The cases line %s does not have the fields its kind needs.", name);
         stop_run();
      end
   endtask

   // **************************************************
   // Main sequence
   // **************************************************

   initial begin
      int              fd;
      int              n;
      int              cases_run;
      int              f_width;
      string           name;
      string           kind;
      logic [1023:0]   rest;
      uart_pkg::cmd_t  f_cmd;
      uart_pkg::cmd_t  f_other;
      uart_pkg::byte_t f_data;
      logic            f_bad_par;
      logic            f_bad_stop;
      logic            f_perr;
      logic            f_ferr;

      seed      = 33776;
      cases_run = 0;
      rst_n     = 1'b0;
      cmd_in    = '0;
      cmd_vld   = 1'b0;
      rx_drv    = 1'b1;
      loopback  = 1'b0;

      repeat (8) @(negedge clk);
      rst_n = 1'b1;
      @(negedge clk);
      check_flag("reset", "tx", 1'b1, tx);
      check_flag("reset", "cmd_rdy", 1'b1, cmd_rdy);
      check_flag("reset", "read_rdy", 1'b0, read_rdy);
      check_flag("reset", "parity_err", 1'b0, parity_err);
      check_flag("reset", "frame_err", 1'b0, frame_err);

      fd = $fopen("uart_cases.txt", "r");
      if (fd == 0) begin
         $display("The cases file uart_cases.txt could not be opened.");
         stop_run();
      end
      while (!$feof(fd)) begin
         n = $fscanf(fd, "%s", name);
         if (n == 1) begin
            if (name.getc(0) == "#") begin
               n = $fgets(rest, fd);
            end else begin
               n = $fscanf(fd, "%s", kind);
               check_fields(name, n, 1);
               if (kind == "C") begin
                  n = $fscanf(fd, "%h", f_cmd);
                  check_fields(name, n, 1);
                  run_command(name, f_cmd, 1'b0, '0);
               end else if (kind == "D") begin
                  n = $fscanf(fd, "%h %h", f_cmd, f_other);
                  check_fields(name, n, 2);
                  run_command(name, f_cmd, 1'b1, f_other);
               end else if (kind == "R") begin
                  n = $fscanf(fd, "%h %h %h %h %h", f_data, f_bad_par, f_bad_stop,
                              f_perr, f_ferr);
                  check_fields(name, n, 5);
                  run_frame(name, f_data, f_bad_par, f_bad_stop, f_perr, f_ferr);
               end else if (kind == "G") begin
                  n = $fscanf(fd, "%h", f_width);
                  check_fields(name, n, 1);
                  run_glitch(name, f_width);
               end else begin
                  $display("The cases line %s has an unknown kind %s.", name, kind);
                  stop_run();
               end
               cases_run++;
            end
         end
      end
      $fclose(fd);

      for (int k = 0; k < RANDOM_CMDS; k++) begin
         f_cmd = uart_pkg::cmd_t'($random(seed));
         run_command($sformatf("random_%0d", k), f_cmd, 1'b0, '0);
         cases_run++;
      end

      if (cases_run <= RANDOM_CMDS) begin
         $display("No test line was read from the cases file.");
         stop_run();
      end else begin
         $display("Result: PASSED");
         $finish;
      end
   end

endmodule

// ==== uart_top.sv ====
`timescale 1ns/1ps

module uart_top (
   input  logic            clk,
   input  logic            rst_n,

   // Command side.
   input  uart_pkg::cmd_t  cmd_in,
   input  logic            cmd_vld,
   output logic            cmd_rdy,
   output logic            tx,

   // Receive side.
   input  logic            rx,
   output logic            read_rdy,
   output uart_pkg::byte_t read_data,
   output logic            parity_err,
   output logic            frame_err
);

   // **************************************************
   // Transmitter
   // **************************************************

   // Sends each accepted command as two frames, high byte first.
   uart_cmd_tx i_uart_cmd_tx (
      .clk     (clk),
      .rst_n   (rst_n),
      .cmd_in  (cmd_in),
      .cmd_vld (cmd_vld),
      .cmd_rdy (cmd_rdy),
      .tx      (tx)
   );

   // **************************************************
   // Receiver
   // **************************************************

   // The receiver runs on its own line. Loopback is made outside this block.
   uart_frame_rx i_uart_frame_rx (
      .clk        (clk),
      .rst_n      (rst_n),
      .rx         (rx),
      .read_rdy   (read_rdy),
      .read_data  (read_data),
      .parity_err (parity_err),
      .frame_err  (frame_err)
   );

endmodule

// ==== uart_frame_rx.sv ====
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_frame_rx (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            rx,
   output logic            read_rdy,
   output uart_pkg::byte_t read_data,
   output logic            parity_err,
   output logic            frame_err
);

   // The start bit is checked half a bit after the edge, all others a full bit apart.
   localparam uart_pkg::tick_cnt_t HALF_TICK = uart_pkg::tick_cnt_t'(`CLKS_PER_BIT / 2 - 1);
   localparam uart_pkg::tick_cnt_t FULL_TICK = uart_pkg::tick_cnt_t'(`CLKS_PER_BIT - 1);

   // Index of the last data bit. Start, parity and stop make up the rest of a frame.
   localparam uart_pkg::bit_cnt_t LAST_DATA = uart_pkg::bit_cnt_t'(`FRAME_BITS - 4);

   uart_pkg::rx_state_e state;
   uart_pkg::tick_cnt_t tick_cnt;
   uart_pkg::bit_cnt_t  bit_cnt;
   uart_pkg::byte_t     shift_data;

   logic rx_meta;
   logic rx_sync;
   logic rx_last;
   logic rx_fall;
   logic sample;
   logic par_acc;

   // **************************************************
   // Line synchronizer and edge detect
   // **************************************************

   // All three flops rest at the idle line level.
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         rx_meta <= 1'b1;
         rx_sync <= 1'b1;
         rx_last <= 1'b1;
      end else begin
         rx_meta <= rx;
         rx_sync <= rx_meta;
         rx_last <= rx_sync;
      end
   end

   assign rx_fall = rx_last & ~rx_sync;

   // Marks the clock in which the current bit is sampled.
   always_comb begin
      if (state == uart_pkg::RX_START) begin
         sample = (tick_cnt == HALF_TICK);
      end else begin
         sample = (tick_cnt == FULL_TICK);
      end
   end

   // **************************************************
   // Frame FSM
   // **************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state      <= uart_pkg::RX_IDLE;
         tick_cnt   <= '0;
         bit_cnt    <= '0;
         par_acc    <= 1'b0;
         read_rdy   <= 1'b0;
         parity_err <= 1'b0;
         frame_err  <= 1'b0;
      end else begin
         read_rdy <= 1'b0;

         // The tick counter restarts at every sample and rests while idle.
         if ((state == uart_pkg::RX_IDLE) || sample) begin
            tick_cnt <= '0;
         end else begin
            tick_cnt <= tick_cnt + 1'b1;
         end

         case (state)
            uart_pkg::RX_IDLE: begin
               if (rx_fall) begin
                  state <= uart_pkg::RX_START;
               end
            end

            uart_pkg::RX_START: begin
               if (sample) begin
                  // A line that is high again here was only a glitch.
                  if (!rx_sync) begin
                     state   <= uart_pkg::RX_DATA;
                     bit_cnt <= '0;
                     par_acc <= 1'b0;
                  end else begin
                     state <= uart_pkg::RX_IDLE;
                  end
               end
            end

            uart_pkg::RX_DATA: begin
               if (sample) begin
                  par_acc <= par_acc ^ rx_sync;
                  bit_cnt <= bit_cnt + 1'b1;
                  if (bit_cnt == LAST_DATA) begin
                     state <= uart_pkg::RX_PARITY;
                  end
               end
            end

            uart_pkg::RX_PARITY: begin
               if (sample) begin
                  par_acc <= par_acc ^ rx_sync;
                  state   <= uart_pkg::RX_STOP;
               end
            end

            uart_pkg::RX_STOP: begin
               if (sample) begin
                  // Data plus parity must hold an odd number of ones.
                  read_rdy   <= 1'b1;
                  parity_err <= ~par_acc;
                  frame_err  <= ~rx_sync;
                  state      <= uart_pkg::RX_IDLE;
               end
            end

            default: begin
               state <= uart_pkg::RX_IDLE;
            end
         endcase
      end
   end

   // Data bits arrive least significant first and shift in from the top.
   always_ff @(posedge clk) begin
      if ((state == uart_pkg::RX_DATA) && sample) begin
         shift_data <= {rx_sync, shift_data[7:1]};
      end
      if ((state == uart_pkg::RX_STOP) && sample) begin
         read_data <= shift_data;
      end
   end

   // **************************************************
   // Checks
   // **************************************************

   a_rdy_one_cycle : assert property (
      @(posedge clk) disable iff (!rst_n)
      read_rdy |=> !read_rdy
   );

   a_rdy_after_stop : assert property (
      @(posedge clk) disable iff (!rst_n)
      read_rdy |-> ($past(state) == uart_pkg::RX_STOP)
   );

endmodule

// ==== uart_cmd_tx.sv ====
`timescale 1ns/1ps
`include "uart_defs.svh"

module uart_cmd_tx (
   input  logic           clk,
   input  logic           rst_n,
   input  uart_pkg::cmd_t cmd_in,
   input  logic           cmd_vld,
   output logic           cmd_rdy,
   output logic           tx
);

   // Two frames go out back to back for every command.
   localparam int IMG_BITS = 2 * `FRAME_BITS;

   localparam uart_pkg::tick_cnt_t LAST_TICK = uart_pkg::tick_cnt_t'(`CLKS_PER_BIT - 1);
   localparam uart_pkg::bit_cnt_t  LAST_BIT  = uart_pkg::bit_cnt_t'(IMG_BITS - 1);
   localparam uart_pkg::bit_cnt_t  MAX_BITS  = uart_pkg::bit_cnt_t'(IMG_BITS);

   uart_pkg::tx_state_e state;
   uart_pkg::tick_cnt_t tick_cnt;
   uart_pkg::bit_cnt_t  bit_cnt;

   logic [IMG_BITS-1:0] shift_img;
   logic [IMG_BITS-1:0] load_img;
   logic                accept;
   logic                bit_end;

   // Builds one frame in line order with odd parity over the data byte.
   function automatic uart_pkg::frame_t build_frame(input uart_pkg::byte_t data);
      uart_pkg::frame_t frame;
      frame = {1'b1, ~^data, data, 1'b0};
      return frame;
   endfunction

   // **************************************************
   // Command capture
   // **************************************************

   assign accept = cmd_vld && cmd_rdy && (state == uart_pkg::TX_IDLE);

   // Bit 0 of the image leaves first, so the high byte frame sits at the bottom.
   assign load_img = {build_frame(cmd_in[7:0]), build_frame(cmd_in[15:8])};

   assign bit_end = (tick_cnt == LAST_TICK);

   // **************************************************
   // Bit timing and state
   // **************************************************

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state    <= uart_pkg::TX_IDLE;
         cmd_rdy  <= 1'b1;
         tx       <= 1'b1;
         tick_cnt <= '0;
         bit_cnt  <= '0;
      end else begin
         case (state)
            uart_pkg::TX_IDLE: begin
               if (accept) begin
                  // The start bit is on the line in the very next cycle.
                  state    <= uart_pkg::TX_SEND;
                  cmd_rdy  <= 1'b0;
                  tx       <= load_img[0];
                  tick_cnt <= '0;
                  bit_cnt  <= '0;
               end
            end

            uart_pkg::TX_SEND: begin
               if (bit_end) begin
                  tick_cnt <= '0;
                  bit_cnt  <= bit_cnt + 1'b1;
                  if (bit_cnt == LAST_BIT) begin
                     // The low byte stop bit has run its full length.
                     state   <= uart_pkg::TX_IDLE;
                     cmd_rdy <= 1'b1;
                     tx      <= 1'b1;
                  end else begin
                     tx <= shift_img[0];
                  end
               end else begin
                  tick_cnt <= tick_cnt + 1'b1;
               end
            end

            default: begin
               state   <= uart_pkg::TX_IDLE;
               cmd_rdy <= 1'b1;
               tx      <= 1'b1;
            end
         endcase
      end
   end

   // Bit 0 always carries the next bit to put on tx.
   always_ff @(posedge clk) begin
      if (accept) begin
         shift_img <= load_img >> 1;
      end else if ((state == uart_pkg::TX_SEND) && bit_end) begin
         shift_img <= shift_img >> 1;
      end
   end

   // **************************************************
   // Checks
   // **************************************************

   a_rdy_low_in_send : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == uart_pkg::TX_SEND) |-> !cmd_rdy
   );

   a_line_idle_high : assert property (
      @(posedge clk) disable iff (!rst_n)
      (state == uart_pkg::TX_IDLE) |-> tx
   );

   a_bit_cnt_range : assert property (
      @(posedge clk) disable iff (!rst_n)
      bit_cnt <= MAX_BITS
   );

endmodule

// ==== uart_pkg.sv ====
`include "uart_defs.svh"

package uart_pkg;

   // One data byte on the serial line.
   typedef logic [7:0] byte_t;

   // A 16-bit command. The high byte goes out first.
   typedef logic [15:0] cmd_t;

   // A frame image in line order, bit 0 first.
   // From the top down it holds stop, parity, data and start.
   typedef logic [`FRAME_BITS-1:0] frame_t;

   // Clock count within one serial bit.
   typedef logic [7:0] tick_cnt_t;

   // Bit count. The transmitter counts up to two whole frames.
   typedef logic [4:0] bit_cnt_t;

   typedef enum logic {
      TX_IDLE,
      TX_SEND
   } tx_state_e;

   typedef enum logic [2:0] {
      RX_IDLE,
      RX_START,
      RX_DATA,
      RX_PARITY,
      RX_STOP
   } rx_state_e;

endpackage

// ==== uart_defs.svh ====
`ifndef UART_DEFS_SVH
`define UART_DEFS_SVH

// **************************************************
// Serial bit timing and frame layout.
// **************************************************

// Number of clocks that one serial bit lasts on the line.
// Any even value of 4 or more works. The receiver samples the start bit
// half of this count after the falling edge.
`define CLKS_PER_BIT 8

// Bits per frame. One start bit, eight data bits, an odd parity bit
// and one stop bit.
`define FRAME_BITS 11

`endif
